/* include/pet_defs.svh */
`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// CPU bus widths
`define PET_ADDR_W   16
`define PET_DATA_W   8

// Memory address widths
`define PET_RAM_AW   15    // Main RAM, 32 KB max
`define PET_VRAM_AW  11    // Video RAM, 2 KB
`define PET_EXT_AW   16    // 8096 extension RAM, 64 KB
`define PET_CHAR_AW  12    // Character RAM, two 2 KB sets

// Fixed addresses
`define PET_CR_ADDR  16'hFFF0    // Bank control register
`define PET_IO_PAGE  8'hE8       // I/O page kept visible by peek-through

//////////////////////////////
// Subclock slots within one 32 clock bus cycle
`define PET_CNT_W            5
`define PET_SLOT_FETCH       5'd3     // Video takes the VRAM bus
`define PET_SLOT_COLOUR_FREE 5'd4     // Video owns the bus here
`define PET_SLOT_LOAD        5'd5     // Bus back to CPU, load shifter
`define PET_SLOT_LOAD_END    5'd6     // End of load pulse
`define PET_HALF             5'd16    // Second character in 80 columns

`endif

/* src/pet_pkg.sv */
package pet_pkg;

    // Main RAM size option
    typedef enum logic [1:0] {
        SIZE_8K  = 2'd0,
        SIZE_16K = 2'd1,
        SIZE_32K = 2'd2
    } mem_size_e;

    // Who drives the video RAM address
    typedef enum logic {
        OWNER_VIDEO = 1'b0,
        OWNER_CPU   = 1'b1
    } bus_owner_e;

    // Source for the CPU read data mux
    typedef enum logic [1:0] {
        SRC_RAM  = 2'd0,
        SRC_VRAM = 2'd1,
        SRC_EXT  = 2'd2,
        SRC_OPEN = 2'd3    // Unmapped, returns high address byte
    } read_src_e;

    // Control register at FFF0, 8096 layout
    typedef struct packed {
        logic enable;      // Bit 7, extension RAM on at 8000-FFFF
        logic io_peek;     // Bit 6, E8xx-EFxx stays I/O
        logic scr_peek;    // Bit 5, 8xxx stays screen
        logic spare;       // Bit 4, no function
        logic block3;      // Bit 3, block 3 at C000-FFFF, else block 2
        logic block1;      // Bit 2, block 1 at 8000-BFFF, else block 0
        logic wp_cf;       // Bit 1, write protect C000-FFFF
        logic wp_8b;       // Bit 0, write protect 8000-BFFF
    } bank_ctrl_t;

endpackage

/* src/pet_if.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

//////////////////////////////
// Video strobes from the bus timing block
interface video_strobe_if;
    import pet_pkg::*;

    logic       ce_pixel;    // Pixel shift enable
    logic       load_sr;     // Load shifter with new glyph
    bus_owner_e owner;       // Current VRAM owner
    logic       half_sel;    // Counter bit 4, second char in 80 columns

    modport source (output ce_pixel, output load_sr, output owner, output half_sel);
    modport fetch  (input owner, input half_sel);
    modport shift  (input ce_pixel, input load_sr);
endinterface

//////////////////////////////
// CPU side of the video RAM
interface cpu_vram_if;
    logic                      vram_sel;     // Address decodes to VRAM
    logic                      vram_wr;      // CPU write into VRAM
    logic [`PET_VRAM_AW-1:0]   vram_addr;    // Folded for 40/80 columns
    logic [`PET_DATA_W-1:0]    wdata;
    logic [`PET_DATA_W-1:0]    rdata;        // Back from the VRAM

    modport cpu  (output vram_sel, output vram_wr, output vram_addr, output wdata,
                  input rdata);
    modport vram (input vram_sel, input vram_wr, input vram_addr, input wdata,
                  output rdata);
endinterface

/* src/pet_ram.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

// Single port RAM, read data registered
module pet_ram #(
    parameter int AW = 11
) (
    input  logic                   clk,
    input  logic                   we_i,
    input  logic [AW-1:0]          addr_i,
    input  logic [`PET_DATA_W-1:0] wdata_i,
    output logic [`PET_DATA_W-1:0] rdata_o
);

    logic [`PET_DATA_W-1:0] mem [2**AW];    // Storage, contents undefined at start

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];    // Old data on a write cycle
    end

endmodule

/* src/pet_bus_timing.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_bus_timing (
    input  logic           clk,
    input  logic           reset,
    input  logic           have_80_cols_i,
    output logic           ce_1m_o,
    video_strobe_if.source vs
);
    import pet_pkg::*;

    logic [`PET_CNT_W-1:0] cnt;         // Subclock counter with 32 counts per CPU cycle
    logic [`PET_CNT_W-1:0] slot_cnt;    // Counter folded onto first half

    //////////////////////////////
    // Subclock counter
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;    // Wraps 31 -> 0
        end
    end

    assign ce_1m_o     = (cnt == '0);    // One CPU tick per bus cycle
    assign vs.half_sel = cnt[4];

    // 80 columns runs the same schedule again in the second half
    assign slot_cnt = (have_80_cols_i && cnt >= `PET_HALF) ? cnt - `PET_HALF : cnt;

    //////////////////////////////
    // Bus owner, load pulse and pixel strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            vs.owner    <= OWNER_CPU;
            vs.load_sr  <= 1'b0;
            vs.ce_pixel <= 1'b0;
        end else begin
            vs.ce_pixel <= have_80_cols_i ? cnt[0]                   // Every 2 clocks
                                          : (cnt[1:0] == 2'b01);     // Every 4 clocks
            if (slot_cnt == `PET_SLOT_FETCH) begin
                vs.owner <= OWNER_VIDEO;     // Video fetches screen code
            end else if (slot_cnt == `PET_SLOT_LOAD) begin
                vs.owner   <= OWNER_CPU;     // Glyph on its way and bus back to CPU
                vs.load_sr <= 1'b1;
            end else if (slot_cnt == `PET_SLOT_LOAD_END) begin
                vs.load_sr <= 1'b0;
            end
        end
    end

    // Shifter only loads on a pixel edge
    a_load_on_pixel: assert property (@(posedge clk) disable iff (reset)
        vs.load_sr |-> vs.ce_pixel)
        else $error("load_sr without ce_pixel");

endmodule

/* src/pet_mem_map.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_mem_map (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce_1m_i,
    input  logic [`PET_ADDR_W-1:0] addr_i,
    input  logic [`PET_DATA_W-1:0] data_i,
    input  logic                   we_i,
    input  pet_pkg::mem_size_e     ram_size_i,
    input  logic                   have_8096_i,
    input  logic                   have_80_cols_i,
    output logic [`PET_DATA_W-1:0] data_o,
    cpu_vram_if.cpu                cv
);
    import pet_pkg::*;

    localparam logic [7:0] IO_PAGE = `PET_IO_PAGE;

    bank_ctrl_t              cr;          // FFF0 control register
    logic                    ram_sel;
    logic                    ram_we;
    logic [`PET_DATA_W-1:0]  ram_rdata;
    logic                    ext_sel;
    logic                    ext_we;
    logic [`PET_EXT_AW-1:0]  ext_addr;
    logic [`PET_DATA_W-1:0]  ext_rdata;
    read_src_e               rd_src;

    //////////////////////////////
    // Bank control register, write only on the CPU tick
    always_ff @(posedge clk) begin
        if (reset) begin
            cr <= '0;    // Extension off
        end else if (ce_1m_i && we_i && have_8096_i && addr_i == `PET_CR_ADDR) begin
            cr <= bank_ctrl_t'(data_i);
        end
    end

    //////////////////////////////
    // Main RAM, sized by option
    always_comb begin
        unique case (ram_size_i)
            SIZE_32K: ram_sel = !addr_i[15];              // 0000-7FFF
            SIZE_16K: ram_sel = (addr_i[15:14] == 2'b00); // 0000-3FFF
            default:  ram_sel = (addr_i[15:13] == 3'b000); // 0000-1FFF
        endcase
    end

    assign ram_we = we_i && ram_sel;    // Written every clock of the cycle

    pet_ram #(.AW(`PET_RAM_AW)) u_main_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (addr_i[`PET_RAM_AW-1:0]),
        .wdata_i (data_i),
        .rdata_o (ram_rdata)
    );

    //////////////////////////////
    // Extension RAM over 8000-FFFF
    assign ext_sel = addr_i[15] && cr.enable && have_8096_i
                  && !(cr.scr_peek && addr_i[15:12] == 4'h8)         // Screen peek-through
                  && !(cr.io_peek && addr_i[15:11] == IO_PAGE[7:3]); // E800-EFFF peek

    // Write protect per 16 KB half
    assign ext_we = we_i && ext_sel
                 && !(cr.wp_8b && !addr_i[14])
                 && !(cr.wp_cf && addr_i[14]);

    // Upper or lower half, then block select, then offset
    assign ext_addr = {addr_i[14], (addr_i[14] ? cr.block3 : cr.block1), addr_i[13:0]};

    pet_ram #(.AW(`PET_EXT_AW)) u_ext_ram (
        .clk     (clk),
        .we_i    (ext_we),
        .addr_i  (ext_addr),
        .wdata_i (data_i),
        .rdata_o (ext_rdata)
    );

    //////////////////////////////
    // Video RAM decode, 8000-87FF only
    assign cv.vram_sel  = !ext_sel && (addr_i[15:11] == 5'b10000);
    assign cv.vram_wr   = we_i && cv.vram_sel;
    assign cv.vram_addr = {addr_i[10] & have_80_cols_i, addr_i[9:0]};  // 40 cols mirrors 8400
    assign cv.wdata     = data_i;

    // Read source, extension RAM wins
    always_comb begin
        if (ext_sel) begin
            rd_src = SRC_EXT;
        end else if (cv.vram_sel) begin
            rd_src = SRC_VRAM;
        end else if (ram_sel) begin
            rd_src = SRC_RAM;
        end else begin
            rd_src = SRC_OPEN;
        end
    end

    always_comb begin
        unique case (rd_src)
            SRC_RAM:  data_o = ram_rdata;
            SRC_VRAM: data_o = cv.rdata;
            SRC_EXT:  data_o = ext_rdata;
            default:  data_o = addr_i[15:8];    // Floating bus
        endcase
    end

    a_one_ram_write: assert property (@(posedge clk) disable iff (reset)
        !(ram_we && ext_we))
        else $error("Main and extension RAM written together");

endmodule

/* src/pet_video_fetch.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_video_fetch (
    input  logic                    clk,
    input  logic                    have_80_cols_i,
    input  logic [13:0]             crtc_ma_i,
    input  logic [4:0]              crtc_ra_i,
    input  logic                    gfx_i,
    input  logic                    char_we_i,
    input  logic [`PET_CHAR_AW-1:0] char_addr_i,
    input  logic [`PET_DATA_W-1:0]  char_data_i,
    cpu_vram_if.vram                cv,
    video_strobe_if.fetch           vs,
    output logic [`PET_DATA_W-1:0]  glyph_o,
    output logic                    rev_o
);
    import pet_pkg::*;

    logic                      cpu_has_bus;
    logic                      vram_we;
    logic [`PET_VRAM_AW-1:0]   video_addr;
    logic [`PET_VRAM_AW-1:0]   vram_addr;
    logic [`PET_CHAR_AW-1:0]   glyph_addr;
    logic [`PET_CHAR_AW-1:0]   char_addr;

    //////////////////////////////
    // Video RAM address mux
    // 80 columns fetches two codes per cycle, half_sel picks which
    assign video_addr = have_80_cols_i ? {crtc_ma_i[9:0], vs.half_sel}
                                       : {1'b0, crtc_ma_i[9:0]};

    assign cpu_has_bus = cv.vram_sel && (vs.owner == OWNER_CPU);
    assign vram_addr   = cpu_has_bus ? cv.vram_addr : video_addr;
    assign vram_we     = cv.vram_wr && (vs.owner == OWNER_CPU);    // Held off during fetch

    pet_ram #(.AW(`PET_VRAM_AW)) u_vram (
        .clk     (clk),
        .we_i    (vram_we),
        .addr_i  (vram_addr),
        .wdata_i (cv.wdata),
        .rdata_o (cv.rdata)     // Also screen code for video
    );

    //////////////////////////////
    // Character RAM
    // MA13 picks the char set half, gfx picks upper/lower case
    assign glyph_addr = {crtc_ma_i[13], gfx_i, cv.rdata[6:0], crtc_ra_i[2:0]};
    assign char_addr  = char_we_i ? char_addr_i : glyph_addr;    // Load port takes over

    pet_ram #(.AW(`PET_CHAR_AW)) u_char_ram (
        .clk     (clk),
        .we_i    (char_we_i),
        .addr_i  (char_addr),
        .wdata_i (char_data_i),
        .rdata_o (glyph_o)
    );

    // Reverse bit lines up with the glyph one clock later
    always_ff @(posedge clk) begin
        rev_o <= cv.rdata[7];
    end

    a_no_write_in_fetch: assert property (@(posedge clk)
        !(vram_we && vs.owner == OWNER_VIDEO))
        else $error("VRAM write while video owns the bus");

endmodule

/* src/pet_pixel_shifter.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_pixel_shifter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   crtc_de_i,
    input  logic [4:0]             crtc_ra_i,
    input  logic [13:0]            crtc_ma_i,
    input  logic [`PET_DATA_W-1:0] glyph_i,
    input  logic                   rev_i,
    video_strobe_if.shift          vs,
    output logic                   pix_o
);

    logic [`PET_DATA_W-1:0] sr;        // Pixel shift register
    logic                   rev_q;     // Reverse video for current char
    logic                   no_row;    // Gap rows between text lines
    logic                   invert;    // Whole screen invert

    assign no_row = crtc_ra_i[3] || crtc_ra_i[4];    // RA 8 or more
    assign invert = !crtc_ma_i[12];

    //////////////////////////////
    // Load or shift on the pixel strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            sr    <= '0;
            rev_q <= 1'b0;
        end else if (vs.ce_pixel) begin
            if (vs.load_sr) begin
                // Blank outside display and in gap rows
                {rev_q, sr} <= (crtc_de_i && !no_row) ? {rev_i, glyph_i}
                                                      : '0;
            end else begin
                sr <= {sr[`PET_DATA_W-2:0], 1'b0};    // MSB first
            end
        end
    end

    // Pixel with reverse and invert applied
    assign pix_o = sr[`PET_DATA_W-1] ^ rev_q ^ invert;

endmodule

/* src/pet_core.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_core (
    input  logic                    clk,
    input  logic                    reset,
    // CPU bus
    input  logic [`PET_ADDR_W-1:0]  addr_i,
    input  logic [`PET_DATA_W-1:0]  data_i,
    input  logic                    we_i,
    output logic [`PET_DATA_W-1:0]  data_o,
    // Options
    input  pet_pkg::mem_size_e      ram_size_i,
    input  logic                    have_8096_i,
    input  logic                    have_80_cols_i,
    // Character RAM load port
    input  logic                    char_we_i,
    input  logic [`PET_CHAR_AW-1:0] char_addr_i,
    input  logic [`PET_DATA_W-1:0]  char_data_i,
    // From the CRTC
    input  logic                    crtc_de_i,
    input  logic [13:0]             crtc_ma_i,
    input  logic [4:0]              crtc_ra_i,
    input  logic                    gfx_i,
    // Strobes and video
    output logic                    ce_1m_o,
    output logic                    ce_pixel_o,
    output logic                    pix_o
);

    video_strobe_if vid_strobe ();    // Timing to fetch and shifter
    cpu_vram_if     cpu_vram ();      // Memory map to VRAM

    logic [`PET_DATA_W-1:0] glyph;
    logic                   rev;

    assign ce_pixel_o = vid_strobe.ce_pixel;

    //////////////////////////////
    pet_bus_timing u_timing (
        .clk            (clk),
        .reset          (reset),
        .have_80_cols_i (have_80_cols_i),
        .ce_1m_o        (ce_1m_o),
        .vs             (vid_strobe.source)
    );

    pet_mem_map u_mem_map (
        .clk            (clk),
        .reset          (reset),
        .ce_1m_i        (ce_1m_o),
        .addr_i         (addr_i),
        .data_i         (data_i),
        .we_i           (we_i),
        .ram_size_i     (ram_size_i),
        .have_8096_i    (have_8096_i),
        .have_80_cols_i (have_80_cols_i),
        .data_o         (data_o),
        .cv             (cpu_vram.cpu)
    );

    pet_video_fetch u_fetch (
        .clk            (clk),
        .have_80_cols_i (have_80_cols_i),
        .crtc_ma_i      (crtc_ma_i),
        .crtc_ra_i      (crtc_ra_i),
        .gfx_i          (gfx_i),
        .char_we_i      (char_we_i),
        .char_addr_i    (char_addr_i),
        .char_data_i    (char_data_i),
        .cv             (cpu_vram.vram),
        .vs             (vid_strobe.fetch),
        .glyph_o        (glyph),
        .rev_o          (rev)
    );

    pet_pixel_shifter u_shifter (
        .clk            (clk),
        .reset          (reset),
        .crtc_de_i      (crtc_de_i),
        .crtc_ra_i      (crtc_ra_i),
        .crtc_ma_i      (crtc_ma_i),
        .glyph_i        (glyph),
        .rev_i          (rev),
        .vs             (vid_strobe.shift),
        .pix_o          (pix_o)
    );

endmodule

/* sim/pet_core_tb.sv */
`timescale 1ns/100ps
`include "pet_defs.svh"

module pet_core_tb;
    import pet_pkg::*;

    localparam logic [7:0] GLYPH_A = 8'h1D;    // No rotational symmetry
    localparam logic [7:0] GLYPH_B = 8'h6B;

    typedef struct packed {
        logic [`PET_ADDR_W-1:0] addr;
        logic [`PET_DATA_W-1:0] data;
        logic                   we;
        mem_size_e              size;
        logic                   has_8096;
        logic [`PET_DATA_W-1:0] exp_data;    // Checked on reads only
    } mem_step_t;

    logic                    clk, reset;
    logic [`PET_ADDR_W-1:0]  addr_i;
    logic [`PET_DATA_W-1:0]  data_i, data_o, char_data_i;
    logic                    we_i, have_8096_i, have_80_cols_i, char_we_i;
    mem_size_e               ram_size_i;
    logic [`PET_CHAR_AW-1:0] char_addr_i;
    logic                    crtc_de_i, gfx_i, ce_1m_o, ce_pixel_o, pix_o;
    logic [13:0]             crtc_ma_i;
    logic [4:0]              crtc_ra_i;

    mem_step_t              steps [$];    // Stimulus table
    logic [31:0]            rng;
    logic [`PET_DATA_W-1:0] rnd [10];
    logic [`PET_DATA_W-1:0] rd;

    pet_core dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    //////////////////////////////
    // Checks and waits
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_byte(input string name, input logic [`PET_DATA_W-1:0] got,
                              input logic [`PET_DATA_W-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s got %02h expected %02h",
                               $time, name, got, exp));
    endtask

    task automatic check_pix(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic sync_ce_1m();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 40) stop_run("Timed out waiting for ce_1m_o");
        end while (!ce_1m_o);
    endtask

    task automatic next_pixel();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 8) stop_run("Timed out waiting for ce_pixel_o");
        end while (!ce_pixel_o);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////
    // CPU bus cycles
    function automatic mem_step_t make_step(input logic [15:0] addr, input logic [7:0] data,
                                            input logic we, input mem_size_e size,
                                            input logic has_8096, input logic [7:0] exp_data);
        return '{addr, data, we, size, has_8096, exp_data};
    endfunction

    task automatic write_step(input logic [15:0] a, input logic [7:0] d,
                              input mem_size_e sz, input logic b8096);
        steps.push_back(make_step(a, d, 1'b1, sz, b8096, 8'h00));
    endtask

    task automatic read_step(input logic [15:0] a, input logic [7:0] e,
                             input mem_size_e sz, input logic b8096);
        steps.push_back(make_step(a, 8'h00, 1'b0, sz, b8096, e));
    endtask

    // Drive just after ce_1m_o and sample data_o at the next one
    task automatic cpu_cycle(input mem_step_t s, output logic [`PET_DATA_W-1:0] rdata);
        if (!ce_1m_o) sync_ce_1m();
        @(negedge clk);
        addr_i      = s.addr;
        data_i      = s.data;
        we_i        = s.we;
        ram_size_i  = s.size;
        have_8096_i = s.has_8096;
        sync_ce_1m();
        rdata = data_o;
    endtask

    task automatic vram_write(input logic [15:0] addr, input logic [7:0] code);
        logic [7:0] ignored;
        cpu_cycle(make_step(addr, code, 1'b1, SIZE_32K, 1'b0, 8'h00), ignored);
        cpu_cycle(make_step(16'h0000, 8'h00, 1'b0, SIZE_32K, 1'b0, 8'h00), ignored);  // Off VRAM
    endtask

    task automatic load_char(input logic [`PET_CHAR_AW-1:0] addr, input logic [7:0] glyph);
        @(negedge clk);
        char_we_i   = 1'b1;
        char_addr_i = addr;
        char_data_i = glyph;
        @(negedge clk);
        char_we_i   = 1'b0;
    endtask

    //////////////////////////////
    // Pixel stream checks
    // Rotation of pat nearest to got so that a bad pixel shows as one mismatch
    function automatic logic [15:0] closest_rotation(input logic [15:0] got,
                                                     input logic [15:0] pat);
        logic [15:0] rot;
        logic [15:0] best;
        int          best_err;
        int          err;
        best     = pat;
        best_err = 17;
        for (int k = 0; k < 16; k++) begin
            rot = (pat << k) | (pat >> (16 - k));
            err = $countones(rot ^ got);
            if (err < best_err) begin
                best_err = err;
                best     = rot;
            end
        end
        return best;
    endfunction

    task automatic verify_pixels(input string name, input logic [15:0] pattern);
        logic [15:0] got;
        logic [15:0] exp;
        repeat (2) sync_ce_1m();    // Shifter reloads from new inputs
        for (int i = 15; i >= 0; i--) begin
            next_pixel();
            got[i] = pix_o;         // First pixel in MSB
        end
        exp = closest_rotation(got, pattern);
        for (int i = 15; i >= 0; i--) begin
            check_pix($sformatf("pix_o %s sample %0d", name, 15 - i), got[i], exp[i]);
        end
    endtask

    // Pixel strobes and CPU ticks over one bus cycle
    task automatic count_strobes(input logic [7:0] exp);
        logic [7:0] n;
        logic [7:0] n_1m;
        n    = 8'd0;
        n_1m = 8'd0;
        sync_ce_1m();
        repeat (32) begin           // One bus cycle
            @(negedge clk);
            if (ce_pixel_o) n = n + 8'd1;
            if (ce_1m_o) n_1m = n_1m + 8'd1;
        end
        check_byte("ce_pixel_o count", n, exp);
        check_byte("ce_1m_o count", n_1m, 8'd1);
        check_pix("ce_1m_o after 32 clocks", ce_1m_o, 1'b1);    // Single tick ends the cycle
    endtask

    //////////////////////////////
    initial begin
        reset          = 1'b1;
        addr_i         = '0;
        data_i         = '0;
        we_i           = 1'b0;
        ram_size_i     = SIZE_32K;
        have_8096_i    = 1'b0;
        have_80_cols_i = 1'b0;
        char_we_i      = 1'b0;
        char_addr_i    = '0;
        char_data_i    = '0;
        crtc_de_i      = 1'b1;
        crtc_ma_i      = 14'h1040;    // MA12 set with screen address 040
        crtc_ra_i      = 5'd3;
        gfx_i          = 1'b0;
        rng            = 32'h2b2c75c0;
        for (int i = 0; i < 10; i++) begin
            rng    = xorshift32(rng);
            rnd[i] = rng[7:0];
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // Main RAM under each size where writes above the size are lost
        write_step(16'h0010, rnd[0], SIZE_32K, 1'b0);
        write_step(16'h7FFF, rnd[1], SIZE_32K, 1'b0);
        write_step(16'h2005, rnd[2], SIZE_32K, 1'b0);
        write_step(16'h4321, rnd[3], SIZE_32K, 1'b0);
        read_step(16'h0010, rnd[0], SIZE_32K, 1'b0);
        read_step(16'h7FFF, rnd[1], SIZE_32K, 1'b0);
        write_step(16'h0020, rnd[4], SIZE_8K, 1'b0);
        write_step(16'h2005, rnd[5], SIZE_8K, 1'b0);    // Above 8K
        read_step(16'h0020, rnd[4], SIZE_8K, 1'b0);
        read_step(16'h2005, 8'h20, SIZE_8K, 1'b0);
        read_step(16'h7FFF, 8'h7F, SIZE_8K, 1'b0);
        write_step(16'h4321, rnd[6], SIZE_16K, 1'b0);   // Above 16K
        read_step(16'h2005, rnd[2], SIZE_16K, 1'b0);
        read_step(16'h4321, 8'h43, SIZE_16K, 1'b0);
        read_step(16'h4321, rnd[3], SIZE_32K, 1'b0);
        // Video RAM with 8400 mirroring 8000 in 40 columns
        write_step(16'h8000, rnd[7], SIZE_32K, 1'b0);
        write_step(16'h83FF, rnd[8], SIZE_32K, 1'b0);
        read_step(16'h8000, rnd[7], SIZE_32K, 1'b0);
        read_step(16'h8400, rnd[7], SIZE_32K, 1'b0);
        read_step(16'h87FF, rnd[8], SIZE_32K, 1'b0);
        read_step(16'h8800, 8'h88, SIZE_32K, 1'b0);
        // Bank switching
        write_step(`PET_CR_ADDR, 8'h80, SIZE_32K, 1'b1);    // Block 0
        write_step(16'h8010, rnd[9], SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'h84, SIZE_32K, 1'b1);    // Block 1
        write_step(16'h8010, rnd[9] ^ 8'h5A, SIZE_32K, 1'b1);
        read_step(16'h8010, rnd[9] ^ 8'h5A, SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'h80, SIZE_32K, 1'b1);
        read_step(16'h8010, rnd[9], SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'h81, SIZE_32K, 1'b1);    // wp_8b
        write_step(16'h8010, ~rnd[9], SIZE_32K, 1'b1);
        read_step(16'h8010, rnd[9], SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'hA0, SIZE_32K, 1'b1);    // scr_peek
        read_step(16'h8000, rnd[7], SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'h00, SIZE_32K, 1'b1);
        write_step(`PET_CR_ADDR, 8'h84, SIZE_32K, 1'b0);    // Ignored without 8096
        read_step(16'h8000, rnd[7], SIZE_32K, 1'b1);

        foreach (steps[i]) begin
            cpu_cycle(steps[i], rd);
            if (!steps[i].we)
                check_byte($sformatf("data_o at %04h", steps[i].addr), rd, steps[i].exp_data);
        end

        // Glyphs for codes 12 and 25 on row 3
        load_char(12'h093, GLYPH_A);
        load_char(12'h12B, GLYPH_B);
        vram_write(16'h8040, 8'h12);
        verify_pixels("plain", {GLYPH_A, GLYPH_A});
        vram_write(16'h8040, 8'h92);                 // Reverse video
        verify_pixels("reverse", ~{GLYPH_A, GLYPH_A});
        vram_write(16'h8040, 8'h12);
        crtc_ma_i = 14'h0040;                        // MA12 low inverts
        verify_pixels("invert", ~{GLYPH_A, GLYPH_A});
        crtc_ma_i = 14'h1040;
        crtc_de_i = 1'b0;
        verify_pixels("de low", 16'h0000);
        crtc_de_i = 1'b1;
        crtc_ra_i = 5'd9;                            // Gap row
        crtc_ma_i = 14'h0040;
        verify_pixels("ra 9", 16'hFFFF);
        crtc_ra_i = 5'd3;
        crtc_ma_i = 14'h1040;
        count_strobes(8'd8);

        // 80 columns fetch two codes per bus cycle
        have_80_cols_i = 1'b1;
        vram_write(16'h8080, 8'h12);
        vram_write(16'h8081, 8'h25);
        count_strobes(8'd16);
        verify_pixels("80 col", {GLYPH_A, GLYPH_B});

        $display("** PASS **");
        $finish;
    end

endmodule

/* pet_mem.f */
+incdir+include
src/pet_pkg.sv
src/pet_if.sv
src/pet_ram.sv
src/pet_bus_timing.sv
src/pet_mem_map.sv
src/pet_video_fetch.sv
src/pet_pixel_shifter.sv
src/pet_core.sv
sim/pet_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pet_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module pet_core_tb \
    -f pet_mem.f

sim_out=$(./obj_dir/Vpet_core_tb) || true
echo "$sim_out"

if grep -qxF '** PASS **' <<< "$sim_out"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
